/* source/psg_defs.svh */
// Sizing for the wave-table sound generator.
// Channel count may be set from 2 to 8; PSG_CH_BITS must cover it.
// Address splits into table select (upper) and phase byte (lower).
// Volume is unsigned, samples and the mix are two's complement.
`ifndef PSG_DEFS_SVH
`define PSG_DEFS_SVH

// voice count and channel index width
`define PSG_CHANNELS 8
`define PSG_CH_BITS  3

// sample path
`define PSG_SAMPLE_W 8   // signed wave-table entry
`define PSG_OUT_W    16  // signed mix, worst case 8*128*15 fits

// sample memory, four tables of 256 entries
`define PSG_ADDR_W   10
`define PSG_TBL_W    2   // table select bits on top of the address

// per-channel registers
`define PSG_PHASE_W  16  // phase accumulator and increment
`define PSG_VOL_W    4   // volume 0..15

`endif

/* source/psgPkg.sv */
// Shared types for the wave-table generator.
// Register writes carry a 16-bit data word; narrower fields use its low bits.
`include "psg_defs.svh"

package psgPkg;

	// register field targeted by a write
	typedef enum logic [1:0] {
		fieldInc   = 2'd0, // frequency increment, also clears phase
		fieldTable = 2'd1, // table select
		fieldVol   = 2'd2, // volume
		fieldEn    = 2'd3  // channel enable
	} regField_e;

	typedef struct packed {
		logic [`PSG_CH_BITS-1:0] chan;   // target channel
		regField_e field;
		logic [`PSG_PHASE_W-1:0] data;   // low bits used for narrow fields
	} regWrite_t;

	typedef struct packed {
		logic [`PSG_ADDR_W-1:0] addr;
		logic signed [`PSG_SAMPLE_W-1:0] sample;
	} memWrite_t;

	// configuration as held inside one channel
	typedef struct packed {
		logic [`PSG_PHASE_W-1:0] inc;
		logic [`PSG_TBL_W-1:0] tbl;
		logic [`PSG_VOL_W-1:0] vol;
		logic en;
	} chanCfg_t;

endpackage

/* source/psgBusArb.sv */
// Fixed-priority arbiter for the shared sample bus.
// Grant moves only on a cycle with ce and ack both high.
// Lowest-numbered requester wins; with no request the last owner keeps the bus.
`timescale 1ns/1ps
`include "psg_defs.svh"

module psgBusArb (
	input  logic clk,
	input  logic rst,
	input  logic ce,                          // arbitration clock enable
	input  logic ack,                         // bus free or transfer done
	input  logic [`PSG_CHANNELS-1:0] req,
	output logic [`PSG_CHANNELS-1:0] sel,     // one-hot grant
	output logic [`PSG_CH_BITS-1:0] seln      // index of owner
);

	logic [`PSG_CHANNELS-1:0] nextSel;
	logic [`PSG_CH_BITS-1:0] nextSeln;

	// scan from the top down so the lowest pending index is left standing
	always_comb begin
		nextSel = '0;
		nextSeln = '0;
		for (int i = `PSG_CHANNELS - 1; i >= 0; i--) begin
			if (req[i]) begin
				nextSel = '0;
				nextSel[i] = 1'b1;
				nextSeln = `PSG_CH_BITS'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
		end else if (ce && ack && |req) begin // no request, hold owner
			sel <= nextSel;
			seln <= nextSeln;
		end
	end

endmodule

/* source/waveChannel.sv */
// One wave-table voice.
// Assumes the previous fetch is done before the next tick; a tick with req
// still pending is not supported. Writing the increment restarts the phase.
// Latched sample reads as zero while the channel is disabled.
`timescale 1ns/1ps
`include "psg_defs.svh"

module waveChannel (
	input  logic clk,
	input  logic rst,
	input  logic regWr,                                  // register write strobe
	input  psgPkg::regWrite_t regData,
	input  logic [`PSG_CH_BITS-1:0] chanId,               // tied per instance
	input  logic tick,                                   // sample strobe
	input  logic sel,                                    // bus granted to us
	input  logic ack,
	input  logic signed [`PSG_SAMPLE_W-1:0] rdData,
	output logic req,
	output logic [`PSG_ADDR_W-1:0] addr,
	output logic signed [`PSG_SAMPLE_W-1:0] sample,
	output logic [`PSG_VOL_W-1:0] volume
);

	psgPkg::chanCfg_t cfg;
	logic [`PSG_PHASE_W-1:0] phase;
	logic signed [`PSG_SAMPLE_W-1:0] sampleQ; // last fetched entry
	logic served;

	assign served = req && sel && ack; // ack alone may just mean bus idle

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg <= '0;
			phase <= '0;
			req <= 1'b0;
			sampleQ <= '0;
		end else begin
			if (tick && cfg.en) begin
				phase <= phase + cfg.inc; // wraps at 2^16
				req <= 1'b1;
			end else if (served) begin
				req <= 1'b0;
			end
			if (served)
				sampleQ <= rdData;
			// register write after tick so an increment write wins the phase
			if (regWr && regData.chan == chanId) begin
				case (regData.field)
					psgPkg::fieldInc: begin
						cfg.inc <= regData.data;
						phase <= '0;
					end
					psgPkg::fieldTable: cfg.tbl <= regData.data[`PSG_TBL_W-1:0];
					psgPkg::fieldVol:   cfg.vol <= regData.data[`PSG_VOL_W-1:0];
					psgPkg::fieldEn:    cfg.en <= regData.data[0];
					default: ;
				endcase
			end
		end
	end

	// table on top, upper phase byte below
	assign addr = {cfg.tbl, phase[`PSG_PHASE_W-1 -: (`PSG_ADDR_W - `PSG_TBL_W)]};
	assign sample = cfg.en ? sampleQ : '0;
	assign volume = cfg.vol;

endmodule

/* source/waveMem.sv */
// Shared sample memory, 4 tables x 256 signed entries.
// ack is high while idle with no selected request, low in the read cycle,
// and high for one cycle with rdData on the return cycle.
// Memory has no reset; load it before enabling channels.
`timescale 1ns/1ps
`include "psg_defs.svh"

module waveMem (
	input  logic clk,
	input  logic rst,
	input  logic memWr,                              // memory write strobe
	input  psgPkg::memWrite_t memData,
	input  logic req,                                // request of the granted channel
	input  logic [`PSG_ADDR_W-1:0] addr,             // address of the granted channel
	output logic signed [`PSG_SAMPLE_W-1:0] rdData,
	output logic ack
);

	typedef enum logic {stIdle, stReturn} memState_e;

	logic signed [`PSG_SAMPLE_W-1:0] mem [1 << `PSG_ADDR_W];
	memState_e state;

	always_ff @(posedge clk) begin
		if (memWr)
			mem[memData.addr] <= memData.sample;
	end

	always_ff @(posedge clk) begin
		if (state == stIdle && req)
			rdData <= mem[addr]; // valid on the return cycle
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= stIdle;
		else if (state == stIdle)
			state <= req ? stReturn : stIdle;
		else
			state <= stIdle; // one return cycle then free again
	end

	assign ack = (state == stReturn) || !req;

endmodule

/* source/psgMixer.sv */
// Volume-scaled sum of all channel samples.
// No clipping; worst case fits the output width by sizing.
// mixOut is taken on tick, so it holds the samples latched before it.
`timescale 1ns/1ps
`include "psg_defs.svh"

module psgMixer (
	input  logic clk,
	input  logic rst,
	input  logic tick,
	input  logic signed [`PSG_SAMPLE_W-1:0] sample [`PSG_CHANNELS],
	input  logic [`PSG_VOL_W-1:0] volume [`PSG_CHANNELS],
	output logic signed [`PSG_OUT_W-1:0] mixOut,
	output logic mixValid                           // one cycle after tick
);

	logic signed [`PSG_OUT_W-1:0] mixSum;

	always_comb begin
		logic signed [`PSG_OUT_W-1:0] wideSample;
		logic signed [`PSG_OUT_W-1:0] wideVol;
		mixSum = '0;
		for (int i = 0; i < `PSG_CHANNELS; i++) begin
			wideSample = `PSG_OUT_W'(sample[i]);          // sign extend
			wideVol = `PSG_OUT_W'({1'b0, volume[i]});      // volume is unsigned
			mixSum = mixSum + wideSample * wideVol;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mixOut <= '0;
			mixValid <= 1'b0;
		end else begin
			mixValid <= tick;
			if (tick)
				mixOut <= mixSum;
		end
	end

endmodule

/* source/psgTop.sv */
// Wave-table generator top: channels, bus arbiter, sample memory, mixer.
// All fetches must finish between ticks, which needs at least
// 4 x PSG_CHANNELS cycles with ce high per tick period.
// Register and memory writes are single-cycle strobes, no back-pressure.
`timescale 1ns/1ps
`include "psg_defs.svh"

module psgTop (
	input  logic clk,
	input  logic rst,
	input  logic ce,                           // arbitration enable
	input  logic regWr,
	input  psgPkg::regWrite_t regData,
	input  logic memWr,
	input  psgPkg::memWrite_t memData,
	input  logic tick,
	output logic signed [`PSG_OUT_W-1:0] mixOut,
	output logic mixValid
);

	logic [`PSG_CHANNELS-1:0] chanReq;
	logic [`PSG_CHANNELS-1:0] sel;
	logic [`PSG_CH_BITS-1:0] seln;
	logic [`PSG_ADDR_W-1:0] chanAddr [`PSG_CHANNELS];
	logic signed [`PSG_SAMPLE_W-1:0] chanSample [`PSG_CHANNELS];
	logic [`PSG_VOL_W-1:0] chanVol [`PSG_CHANNELS];
	logic selReq;
	logic [`PSG_ADDR_W-1:0] selAddr;
	logic signed [`PSG_SAMPLE_W-1:0] rdData;
	logic ack;

	psgBusArb arb_i (
		.clk(clk), .rst(rst), .ce(ce), .ack(ack),
		.req(chanReq), .sel(sel), .seln(seln)
	);

	for (genvar i = 0; i < `PSG_CHANNELS; i++) begin : g_chan
		waveChannel chan_i (
			.clk(clk), .rst(rst),
			.regWr(regWr), .regData(regData),
			.chanId(`PSG_CH_BITS'(i)),
			.tick(tick), .sel(sel[i]), .ack(ack), .rdData(rdData),
			.req(chanReq[i]), .addr(chanAddr[i]),
			.sample(chanSample[i]), .volume(chanVol[i])
		);
	end

	// owner's request and address onto the memory bus
	assign selReq = chanReq[seln];
	assign selAddr = chanAddr[seln];

	waveMem mem_i (
		.clk(clk), .rst(rst),
		.memWr(memWr), .memData(memData),
		.req(selReq), .addr(selAddr),
		.rdData(rdData), .ack(ack)
	);

	psgMixer mix_i (
		.clk(clk), .rst(rst), .tick(tick),
		.sample(chanSample), .volume(chanVol),
		.mixOut(mixOut), .mixValid(mixValid)
	);

endmodule

/* verif/psgTb_assert.sv */
// Bus checks, bound into the arbiter.
// busReq is the owner's request as the sample memory sees it,
// taken through the same seln mux as the top level.
`timescale 1ns/1ps
`include "psg_defs.svh"

module busChecks (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic ack,
	input logic [`PSG_CHANNELS-1:0] sel,
	input logic [`PSG_CH_BITS-1:0] seln,
	input logic busReq                          // request on the memory side
);

	grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
		else $error("grant vector has more than one bit set");

	selnMatch: assert property (@(posedge clk) disable iff (rst) sel == '0 || sel[seln])
		else $error("grant index does not match grant vector");

	// regrant only on ce and ack
	grantHold: assert property (@(posedge clk) disable iff (rst)
		!(ce && ack) |=> $stable(sel) && $stable(seln))
		else $error("grant moved without ce and ack");

	ackSingle: assert property (@(posedge clk) disable iff (rst)
		busReq && ack |=> !(busReq && ack))
		else $error("ack held two cycles under a request");

endmodule

bind psgBusArb busChecks busChk_i (
	.clk(clk), .rst(rst), .ce(ce), .ack(ack),
	.sel(sel), .seln(seln), .busReq(req[seln])
);

/* verif/psgTb.sv */
// Testbench for the wave-table generator.
// The model mirrors memory, channel config, phase and the sample each voice
// fetched after the last tick. Register and memory writes are made only after
// the fetch window of a tick, never while fetches are in flight.
// Ticks are 64 cycles apart with ce on every second cycle.
`timescale 1ns/1ps
`include "psg_defs.svh"

module psgTb;

	localparam int tickGap = 64;                 // cycles between ticks
	localparam int waitLimit = 3000;             // a memory load takes ~1k cycles
	localparam int runTicks = 1 + 40 + 30 + 20 + 10;

	logic clk = 1'b0;
	logic ce = 1'b0;
	logic rst;
	logic regWr;
	psgPkg::regWrite_t regData;
	logic memWr;
	psgPkg::memWrite_t memData;
	logic tick;
	logic signed [`PSG_OUT_W-1:0] mixOut;
	logic mixValid;

	logic signed [`PSG_SAMPLE_W-1:0] memMirror [1 << `PSG_ADDR_W];
	psgPkg::chanCfg_t cfgMirror [`PSG_CHANNELS];
	logic [`PSG_PHASE_W-1:0] phaseMirror [`PSG_CHANNELS];
	logic signed [`PSG_SAMPLE_W-1:0] latchMirror [`PSG_CHANNELS]; // fetched after last tick
	int expQ [$];                                // expected mix per tick
	string nameQ [$];                            // test name per tick
	string testName;
	integer seed = 55;
	int checkedCount = 0;

	psgTop dut_i (
		.clk(clk), .rst(rst), .ce(ce),
		.regWr(regWr), .regData(regData),
		.memWr(memWr), .memData(memData),
		.tick(tick), .mixOut(mixOut), .mixValid(mixValid)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		ce <= ~ce; // half rate arbitration

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	// sum of volume times latched sample over enabled voices
	function automatic int expectedMix();
		int sum;
		sum = 0;
		for (int c = 0; c < `PSG_CHANNELS; c++) begin
			if (cfgMirror[c].en)
				sum += int'(cfgMirror[c].vol) * int'(latchMirror[c]);
		end
		return sum;
	endfunction

	task automatic loadMemory();
		psgPkg::memWrite_t w;
		for (int a = 0; a < (1 << `PSG_ADDR_W); a++) begin
			w.addr = `PSG_ADDR_W'(a);
			w.sample = `PSG_SAMPLE_W'($random(seed));
			@(posedge clk);
			memWr <= 1'b1;
			memData <= w;
			memMirror[w.addr] = w.sample;
		end
		@(posedge clk);
		memWr <= 1'b0;
	endtask

	task automatic writeReg(input int ch, input psgPkg::regField_e f, input logic [15:0] d);
		psgPkg::regWrite_t w;
		w.chan = `PSG_CH_BITS'(ch);
		w.field = f;
		w.data = d;
		@(posedge clk);
		regWr <= 1'b1;
		regData <= w;
		@(posedge clk);
		regWr <= 1'b0;
		case (f)
			psgPkg::fieldInc: begin
				cfgMirror[ch].inc = d;
				phaseMirror[ch] = '0; // increment write restarts the phase
			end
			psgPkg::fieldTable: cfgMirror[ch].tbl = d[`PSG_TBL_W-1:0];
			psgPkg::fieldVol:   cfgMirror[ch].vol = d[`PSG_VOL_W-1:0];
			default:            cfgMirror[ch].en = d[0];
		endcase
	endtask

	// one tick, then the model fetch for every enabled voice
	task automatic runTick();
		@(negedge clk);
		assert (dut_i.chanReq == '0)
			else stopOnError("a channel fetch was still pending when the tick was due");
		@(posedge clk);
		tick <= 1'b1;
		expQ.push_back(expectedMix());
		nameQ.push_back(testName);
		for (int c = 0; c < `PSG_CHANNELS; c++) begin
			if (cfgMirror[c].en) begin
				phaseMirror[c] += cfgMirror[c].inc; // wraps at 2^16
				latchMirror[c] = memMirror[{cfgMirror[c].tbl, phaseMirror[c][15:8]}];
			end
		end
		@(posedge clk);
		tick <= 1'b0;
		@(negedge clk); // strobe due one cycle after tick
		assert (mixValid) else stopOnError("mixValid did not follow the tick by one cycle");
		repeat (tickGap - 2) @(posedge clk);
	endtask

	initial begin : compareMix
		int waited;
		int expVal;
		string name;
		for (int n = 0; n < runTicks; n++) begin
			waited = 0;
			@(negedge clk);
			while (!mixValid && waited < waitLimit) begin
				@(negedge clk);
				waited++;
			end
			assert (mixValid) else stopOnError("timed out waiting for mixValid");
			assert (expQ.size() > 0) else stopOnError("mixValid came without a tick");
			expVal = expQ.pop_front();
			name = nameQ.pop_front();
			assert (int'(mixOut) == expVal)
				else stopOnError($sformatf("Fail %s: expected %0d, actual %0d",
					name, expVal, mixOut));
			checkedCount++;
		end
	end

	initial begin : stimulus
		int waited;
		rst = 1'b1;
		regWr = 1'b0;
		regData = '0;
		memWr = 1'b0;
		memData = '0;
		tick = 1'b0;
		testName = "reset";
		for (int c = 0; c < `PSG_CHANNELS; c++) begin
			cfgMirror[c] = '0;
			phaseMirror[c] = '0;
			latchMirror[c] = '0;
		end
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		loadMemory(); // no ticks yet, mixValid must stay low
		@(negedge clk);
		assert (mixOut == '0)
			else stopOnError($sformatf("Fail %s: expected 0, actual %0d", testName, mixOut));
		testName = "idle";
		runTick();
		testName = "oneVoice"; // 40 steps of 0x2345 wrap the phase several times
		writeReg(2, psgPkg::fieldTable, 16'd1);
		writeReg(2, psgPkg::fieldVol, 16'd9);
		writeReg(2, psgPkg::fieldInc, 16'h2345);
		writeReg(2, psgPkg::fieldEn, 16'd1);
		repeat (40) runTick();
		testName = "allVoices";
		for (int c = 0; c < `PSG_CHANNELS; c++) begin
			writeReg(c, psgPkg::fieldInc, 16'($random(seed)));
			writeReg(c, psgPkg::fieldTable, 16'($random(seed))); // low bits used
			writeReg(c, psgPkg::fieldVol, 16'($random(seed)));
			writeReg(c, psgPkg::fieldEn, 16'd1);
		end
		repeat (30) runTick();
		testName = "reprogram";
		writeReg(3, psgPkg::fieldInc, 16'h0F00);
		writeReg(5, psgPkg::fieldTable, 16'd3);
		writeReg(0, psgPkg::fieldVol, 16'd15);
		writeReg(6, psgPkg::fieldEn, 16'd0); // disabled voice adds zero
		repeat (20) runTick();
		testName = "memRewrite";
		loadMemory();
		repeat (10) runTick();
		waited = 0;
		while (checkedCount < runTicks && waited < waitLimit) begin
			@(posedge clk);
			waited++;
		end
		if (checkedCount == runTicks) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			stopOnError("the comparing process did not see every mix");
		end
	end

endmodule

/* sim.f */
+incdir+source
source/psgPkg.sv
source/psgBusArb.sv
source/waveChannel.sv
source/waveMem.sv
source/psgMixer.sv
source/psgTop.sv
verif/psgTb_assert.sv
verif/psgTb.sv

/* run.sh */
#!/bin/sh
# Build and run the wave-table generator testbench with Verilator.
verilator --binary --timing --assert --top-module psgTb -f sim.f > build.log 2>&1 \
	|| { cat build.log; exit 1; }
./obj_dir/VpsgTb > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
